// File: design/cpu_defines.svh
// cpu defines
// widths, memory depths, APB address map and the halt word
// shared by the package and every RTL block of the small multi-cycle core

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_DATA_W 32
`define CPU_REG_AW 5

// word address widths of the two 256-word memories
`define CPU_IM_AW 8
`define CPU_DM_AW 8

// pc is byte addressed
`define CPU_PC_W 10
`define CPU_CNT_W 32

`define CPU_APB_AW 16
`define CPU_ADDR_CTRL 16'h0000
`define CPU_ADDR_COUNT 16'h0004
`define CPU_IM_BASE 16'h1000
`define CPU_DM_BASE 16'h2000
`define CPU_REGION_MASK 16'hF000

`define CPU_HALT_WORD 32'h0000_0000

`endif

// File: design/cpu_pkg.sv
// cpu package
// opcode, sub-opcode, state and immediate select encodings,
// the decoded instruction fields, the phase controls and the APB bundles

`include "cpu_defines.svh"

package cpu_pkg;

  typedef enum logic [5:0] {
    TYPE_BASIC = 6'b100000,
    ADDI       = 6'b101000,
    ORI        = 6'b101100,
    XORI       = 6'b101011,
    MOVI       = 6'b100010,
    TYPE_LS    = 6'b011100
  } opcode_e;

  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } basic_op_e;

  typedef enum logic [7:0] {
    LW = 8'b00000010,
    SW = 8'b00001010
  } ls_op_e;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FETCH = 3'd1,
    READ  = 3'd2,
    EXEC  = 3'd3,
    MEM   = 3'd4,
    WRITE = 3'd5
  } state_e;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_e;

  typedef struct packed {
    opcode_e   opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [1:0] sv;
    basic_op_e sub5;
    ls_op_e    sub8;
    logic [4:0] imm5;
    logic [14:0] imm15;
    logic [19:0] imm20;
  } instr_fields_t;

  typedef struct packed {
    logic     im_fetch;
    logic     reg_read;
    logic     alu_execute;
    logic     dm_read;
    logic     dm_write;
    logic     reg_write;
    imm_sel_e imm_sel;
    logic     use_imm;
    logic     wb_from_dm;
  } ctrl_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`CPU_APB_AW-1:0] paddr;
    logic [`CPU_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

endpackage

// File: design/ir_controller.sv
// instruction controller
// steps each instruction through fetch, read, execute, memory and writeback,
// latches the instruction word, decodes its fields and operand selects,
// and keeps the pc and the executed instruction count

`timescale 1ns/1ns
`include "cpu_defines.svh"

module ir_controller (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  logic [`CPU_DATA_W-1:0] instr,
  output cpu_pkg::ctrl_t         ctrl,
  output cpu_pkg::instr_fields_t fields,
  output logic [`CPU_REG_AW-1:0] read_address1,
  output logic [`CPU_REG_AW-1:0] read_address2,
  output logic [`CPU_REG_AW-1:0] write_address,
  output logic [`CPU_IM_AW-1:0]  im_address,
  output logic [`CPU_CNT_W-1:0]  ins_cnt,
  output logic                   busy,
  output logic                   done
);
  import cpu_pkg::*;

  state_e                 state;
  logic [`CPU_DATA_W-1:0] instr_q;
  logic [`CPU_PC_W-1:0]   pc;
  logic                   is_lw;
  logic                   is_sw;
  logic                   is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= IDLE;
      instr_q <= '0;
      pc      <= '0;
      ins_cnt <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= FETCH;
            pc      <= '0;
            ins_cnt <= '0;
            busy    <= 1'b1;
            done    <= 1'b0;
          end
        end
        FETCH: state <= READ;
        READ: begin
          instr_q <= instr;
          // all-zero word ends the run
          if (instr == `CPU_HALT_WORD) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b1;
          end else begin
            state <= EXEC;
          end
        end
        EXEC: state <= MEM;
        MEM:  state <= WRITE;
        WRITE: begin
          state   <= FETCH;
          pc      <= pc + `CPU_PC_W'd4;
          ins_cnt <= ins_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // field slices of the latched word
  assign fields.opcode = opcode_e'(instr_q[30:25]);
  assign fields.rt     = instr_q[24:20];
  assign fields.ra     = instr_q[19:15];
  assign fields.rb     = instr_q[14:10];
  assign fields.sv     = instr_q[9:8];
  assign fields.sub5   = basic_op_e'(instr_q[4:0]);
  assign fields.sub8   = ls_op_e'(instr_q[7:0]);
  assign fields.imm5   = instr_q[14:10];
  assign fields.imm15  = instr_q[14:0];
  assign fields.imm20  = instr_q[19:0];

  assign is_lw  = (fields.opcode == TYPE_LS) && (fields.sub8 == LW);
  assign is_sw  = (fields.opcode == TYPE_LS) && (fields.sub8 == SW);
  assign is_nop = (fields.opcode == TYPE_BASIC) && (fields.sub5 == SRLI) &&
                  (fields.imm5 == '0);

  always_comb begin
    ctrl = '0;
    case (state)
      FETCH: ctrl.im_fetch = 1'b1;
      READ:  ctrl.reg_read = 1'b1;
      EXEC:  ctrl.alu_execute = 1'b1;
      MEM: begin
        ctrl.dm_read  = is_lw;
        ctrl.dm_write = is_sw;
        // store data comes from rt
        ctrl.reg_read = is_sw;
      end
      WRITE: ctrl.reg_write = !(is_sw || is_nop);
      default: ;
    endcase

    case (fields.opcode)
      TYPE_BASIC: ctrl.use_imm = fields.sub5 inside {SRLI, SLLI, ROTRI};
      ADDI: begin
        ctrl.imm_sel = IMM15_SE;
        ctrl.use_imm = 1'b1;
      end
      ORI, XORI: begin
        ctrl.imm_sel = IMM15_ZE;
        ctrl.use_imm = 1'b1;
      end
      MOVI: begin
        ctrl.imm_sel = IMM20_SE;
        ctrl.use_imm = 1'b1;
      end
      default: ;
    endcase
    ctrl.wb_from_dm = is_lw;
  end

  assign read_address1 = fields.ra;
  assign read_address2 = (ctrl.reg_read && state == MEM) ? fields.rt : fields.rb;
  assign write_address = fields.rt;
  assign im_address    = pc[`CPU_PC_W-1:2];

endmodule

// File: design/reg_file.sv
// register file
// 32 x 32 bits, two combinational read ports and one write port,
// register 0 always reads zero

`timescale 1ns/1ns
`include "cpu_defines.svh"

module reg_file (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`CPU_REG_AW-1:0] read_address1,
  input  logic [`CPU_REG_AW-1:0] read_address2,
  input  logic [`CPU_REG_AW-1:0] write_address,
  input  logic                   write_enable,
  input  logic [`CPU_DATA_W-1:0] write_data,
  output logic [`CPU_DATA_W-1:0] read_data1,
  output logic [`CPU_DATA_W-1:0] read_data2
);

  logic [`CPU_DATA_W-1:0] regs [2**`CPU_REG_AW];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_address != '0) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
  assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

// File: design/alu.sv
// alu
// extends the immediate, picks the second operand and computes the
// basic, immediate and load/store address results; the result is
// registered in the execute phase

`timescale 1ns/1ns
`include "cpu_defines.svh"

module alu (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::ctrl_t         ctrl,
  input  cpu_pkg::instr_fields_t fields,
  input  logic [`CPU_DATA_W-1:0] operand_a,
  input  logic [`CPU_DATA_W-1:0] operand_b,
  output logic [`CPU_DATA_W-1:0] result
);
  import cpu_pkg::*;

  localparam int SH_W = $clog2(`CPU_DATA_W);

  logic [`CPU_DATA_W-1:0]   imm_ext;
  logic [`CPU_DATA_W-1:0]   operand_2;
  logic [`CPU_DATA_W-1:0]   alu_out;
  logic [2*`CPU_DATA_W-1:0] rot;

  always_comb begin
    case (ctrl.imm_sel)
      IMM5_ZE:  imm_ext = {{(`CPU_DATA_W-5){1'b0}}, fields.imm5};
      IMM15_SE: imm_ext = {{(`CPU_DATA_W-15){fields.imm15[14]}}, fields.imm15};
      IMM15_ZE: imm_ext = {{(`CPU_DATA_W-15){1'b0}}, fields.imm15};
      IMM20_SE: imm_ext = {{(`CPU_DATA_W-20){fields.imm20[19]}}, fields.imm20};
      default:  imm_ext = '0;
    endcase
  end

  assign operand_2 = ctrl.use_imm ? imm_ext : operand_b;
  // rotate right via doubled word
  assign rot = {operand_a, operand_a} >> operand_2[SH_W-1:0];

  always_comb begin
    alu_out = '0;
    case (fields.opcode)
      TYPE_BASIC: begin
        case (fields.sub5)
          ADD:   alu_out = operand_a + operand_2;
          SUB:   alu_out = operand_a - operand_2;
          AND:   alu_out = operand_a & operand_2;
          OR:    alu_out = operand_a | operand_2;
          XOR:   alu_out = operand_a ^ operand_2;
          SRLI:  alu_out = operand_a >> operand_2[SH_W-1:0];
          SLLI:  alu_out = operand_a << operand_2[SH_W-1:0];
          ROTRI: alu_out = rot[`CPU_DATA_W-1:0];
          default: ;
        endcase
      end
      ADDI:    alu_out = operand_a + operand_2;
      ORI:     alu_out = operand_a | operand_2;
      XORI:    alu_out = operand_a ^ operand_2;
      MOVI:    alu_out = operand_2;
      // byte address ra + (rb << sv)
      TYPE_LS: alu_out = operand_a + (operand_b << fields.sv);
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (ctrl.alu_execute) begin
      result <= alu_out;
    end
  end

endmodule

// File: design/mem_subsystem.sv
// memory subsystem
// APB slave with control, status and count words, plus the instruction
// and data memories; the core owns both memories while a run is busy
// and APB accesses to them are refused with pslverr

`timescale 1ns/1ns
`include "cpu_defines.svh"

module mem_subsystem (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::apb_req_t      apb_req,
  input  logic [`CPU_IM_AW-1:0]  im_address,
  input  logic                   im_fetch,
  input  logic [`CPU_DM_AW-1:0]  dm_address,
  input  logic                   dm_read,
  input  logic                   dm_write,
  input  logic [`CPU_DATA_W-1:0] dm_wdata,
  input  logic                   busy,
  input  logic                   done,
  input  logic [`CPU_CNT_W-1:0]  ins_cnt,
  output cpu_pkg::apb_rsp_t      apb_rsp,
  output logic                   start,
  output logic [`CPU_DATA_W-1:0] instr,
  output logic [`CPU_DATA_W-1:0] dm_rdata
);

  logic [`CPU_DATA_W-1:0] im_mem [2**`CPU_IM_AW];
  logic [`CPU_DATA_W-1:0] dm_mem [2**`CPU_DM_AW];

  logic                   access;
  logic [`CPU_APB_AW-1:0] region;
  logic [`CPU_IM_AW-1:0]  im_index;
  logic [`CPU_DM_AW-1:0]  dm_index;
  logic                   sel_ctrl;
  logic                   sel_count;
  logic                   sel_im;
  logic                   sel_dm;
  logic                   err;
  logic                   im_we;
  logic                   dm_we;
  logic [`CPU_DATA_W-1:0] rdata;

  assign access    = apb_req.psel && apb_req.penable;
  assign region    = apb_req.paddr & `CPU_REGION_MASK;
  assign im_index  = apb_req.paddr[`CPU_IM_AW+1:2];
  assign dm_index  = apb_req.paddr[`CPU_DM_AW+1:2];
  assign sel_ctrl  = apb_req.paddr == `CPU_ADDR_CTRL;
  assign sel_count = apb_req.paddr == `CPU_ADDR_COUNT;
  assign sel_im    = region == `CPU_IM_BASE;
  assign sel_dm    = region == `CPU_DM_BASE;

  always_comb begin
    err = 1'b1;
    if (sel_ctrl) begin
      err = 1'b0;
    end else if (sel_count) begin
      err = apb_req.pwrite;
    end else if (sel_im) begin
      // instruction memory is write only
      err = busy || !apb_req.pwrite;
    end else if (sel_dm) begin
      err = busy;
    end
  end

  always_comb begin
    rdata = '0;
    if (sel_ctrl) begin
      rdata = {{(`CPU_DATA_W-2){1'b0}}, done, busy};
    end else if (sel_count) begin
      rdata = ins_cnt;
    end else if (sel_dm) begin
      rdata = dm_mem[dm_index];
    end
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && err;

  assign start = access && apb_req.pwrite && sel_ctrl && apb_req.pwdata[0];
  assign im_we = access && apb_req.pwrite && sel_im && !err;
  assign dm_we = access && apb_req.pwrite && sel_dm && !err;

  always_ff @(posedge clock) begin
    if (im_we) begin
      im_mem[im_index] <= apb_req.pwdata;
    end
    if (dm_write) begin
      dm_mem[dm_address] <= dm_wdata;
    end else if (dm_we) begin
      dm_mem[dm_index] <= apb_req.pwdata;
    end
  end

  // one cycle latency on the core read ports
  always_ff @(posedge clock) begin
    if (reset) begin
      instr    <= '0;
      dm_rdata <= '0;
    end else begin
      if (im_fetch) begin
        instr <= im_mem[im_address];
      end
      if (dm_read) begin
        dm_rdata <= dm_mem[dm_address];
      end
    end
  end

endmodule

// File: design/cpu_top.sv
// cpu top
// multi-cycle core with an APB slave port for program load, run control,
// status and data memory access

`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top (
  input  logic              clock,
  input  logic              reset,
  input  cpu_pkg::apb_req_t apb_req,
  output cpu_pkg::apb_rsp_t apb_rsp
);
  import cpu_pkg::*;

  ctrl_t                  ctrl;
  instr_fields_t          fields;
  logic [`CPU_REG_AW-1:0] read_address1;
  logic [`CPU_REG_AW-1:0] read_address2;
  logic [`CPU_REG_AW-1:0] write_address;
  logic [`CPU_IM_AW-1:0]  im_address;
  logic [`CPU_CNT_W-1:0]  ins_cnt;
  logic                   busy;
  logic                   done;
  logic                   start;
  logic [`CPU_DATA_W-1:0] instr;
  logic [`CPU_DATA_W-1:0] read_data1;
  logic [`CPU_DATA_W-1:0] read_data2;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] dm_rdata;
  logic [`CPU_DATA_W-1:0] write_data;

  // writeback select
  assign write_data = ctrl.wb_from_dm ? dm_rdata : alu_result;

  ir_controller i_ir_controller (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .instr         (instr),
    .ctrl          (ctrl),
    .fields        (fields),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .im_address    (im_address),
    .ins_cnt       (ins_cnt),
    .busy          (busy),
    .done          (done)
  );

  reg_file i_reg_file (
    .clock         (clock),
    .reset         (reset),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .write_enable  (ctrl.reg_write),
    .write_data    (write_data),
    .read_data1    (read_data1),
    .read_data2    (read_data2)
  );

  alu i_alu (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .fields    (fields),
    .operand_a (read_data1),
    .operand_b (read_data2),
    .result    (alu_result)
  );

  // alu result is a byte address for loads and stores
  mem_subsystem i_mem_subsystem (
    .clock      (clock),
    .reset      (reset),
    .apb_req    (apb_req),
    .im_address (im_address),
    .im_fetch   (ctrl.im_fetch),
    .dm_address (alu_result[`CPU_DM_AW+1:2]),
    .dm_read    (ctrl.dm_read),
    .dm_write   (ctrl.dm_write),
    .dm_wdata   (read_data2),
    .busy       (busy),
    .done       (done),
    .ins_cnt    (ins_cnt),
    .apb_rsp    (apb_rsp),
    .start      (start),
    .instr      (instr),
    .dm_rdata   (dm_rdata)
  );

endmodule

// File: verif/cpu_tb.sv
// cpu testbench
// reads commands from the vector file and drives them as APB transfers
// for program loads, data preloads, runs with done polling, read-back
// compares and accesses that must be refused with pslverr

`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int POLL_LIMIT  = 2000;
  localparam int READY_LIMIT = 16;

  logic     clock;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int       errors;
  int       checks;
  int       cycle_count;

  cpu_top i_cpu_top (
    .clock   (clock),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // setup cycle, then access cycle; response sampled mid access cycle
  task automatic apb_transfer(input logic write, input logic [`CPU_APB_AW-1:0] addr,
                              input logic [`CPU_DATA_W-1:0] wdata,
                              output logic [`CPU_DATA_W-1:0] rdata, output logic slverr);
    int waited;
    @(posedge clock);
    #5;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clock);
    #5;
    apb_req.penable = 1'b1;
    @(negedge clock);
    waited = 0;
    while (!apb_rsp.pready && waited < READY_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (!apb_rsp.pready) begin
      errors++;
      $display("APB slave never raised pready on the access to %h", addr);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clock);
    #5;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic check_slverr(input logic [`CPU_APB_AW-1:0] addr, input logic got,
                              input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: pslverr at %h got %b expected %b", $time, addr, got, exp);
    end
  endtask

  task automatic check_prdata(input logic [`CPU_APB_AW-1:0] addr,
                              input logic [`CPU_DATA_W-1:0] got,
                              input logic [`CPU_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: prdata at %h got %h expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic start_run();
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   slverr;
    apb_transfer(1'b1, `CPU_ADDR_CTRL, 32'h1, rdata, slverr);
    check_slverr(`CPU_ADDR_CTRL, slverr, 1'b0);
  endtask

  // poll the done bit of the control word
  task automatic wait_done();
    logic [`CPU_DATA_W-1:0] status;
    logic                   slverr;
    logic                   seen;
    int                     first_cycle;
    seen        = 1'b0;
    first_cycle = cycle_count;
    while (!seen && (cycle_count - first_cycle) < POLL_LIMIT) begin
      apb_transfer(1'b0, `CPU_ADDR_CTRL, '0, status, slverr);
      seen = status[1];
    end
    if (!seen) begin
      errors++;
      $display("timeout: done bit not set within %0d cycles of the start", POLL_LIMIT);
    end
  endtask

  task automatic run_command(input logic [63:0] cmd, input logic [`CPU_APB_AW-1:0] addr,
                             input logic [`CPU_DATA_W-1:0] data);
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   slverr;
    case (cmd)
      "w": begin
        apb_transfer(1'b1, addr, data, rdata, slverr);
        check_slverr(addr, slverr, 1'b0);
      end
      "r": begin
        apb_transfer(1'b0, addr, '0, rdata, slverr);
        check_slverr(addr, slverr, 1'b0);
        check_prdata(addr, rdata, data);
      end
      "ew": begin
        apb_transfer(1'b1, addr, data, rdata, slverr);
        check_slverr(addr, slverr, 1'b1);
      end
      "er": begin
        apb_transfer(1'b0, addr, '0, rdata, slverr);
        check_slverr(addr, slverr, 1'b1);
      end
      "go":   start_run();
      "wait": wait_done();
      "run": begin
        start_run();
        wait_done();
      end
      default: begin
        errors++;
        $display("unknown vector command %s", cmd);
      end
    endcase
  endtask

  initial begin
    int                     fd;
    int                     c;
    int                     n;
    logic [63:0]            cmd;
    logic [`CPU_APB_AW-1:0] addr;
    logic [`CPU_DATA_W-1:0] data;
    clock       = 1'b0;
    reset       = 1'b1;
    apb_req     = '0;
    errors      = 0;
    checks      = 0;
    repeat (8) @(posedge clock);
    #5;
    reset = 1'b0;

    fd = $fopen("verif/cpu_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file verif/cpu_vectors.txt");
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
          // skip the rest of a comment line
          c = $fgetc(fd);
          while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          n = $fscanf(fd, "%h %h", addr, data);
          if (n != 2) begin
            errors++;
            $display("malformed vector line after command %s", cmd);
          end else begin
            run_command(cmd, addr, data);
          end
        end
      end
      $fclose(fd);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: cpu_top.f
+incdir+design
design/cpu_pkg.sv
design/ir_controller.sv
design/reg_file.sv
design/alu.sv
design/mem_subsystem.sv
design/cpu_top.sv
verif/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_top

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/ir_controller.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/mem_subsystem.sv
      - design/cpu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/cpu_tb.sv

// File: verif/cpu_vectors.txt
# cmd addr data, all hex; w writes, r reads and compares, ew and er expect pslverr
# go writes start, wait polls done, run does both; unused fields are 0
# state after reset
r 0000 00000000
r 0004 00000000
# program A: movi r1/r2, add sub and or xor, addi ori xori, stores from byte 0x80
w 1000 44112345
w 1004 442FFFF0
w 1008 40308800
w 100C 40408801
w 1010 40508802
w 1014 40608804
w 1018 40708803
w 101C 5080FFFF
w 1020 5890F000
w 1024 56A14321
w 1028 44B00080
w 102C 3825800A
w 1030 50B58004
w 1034 3835800A
w 1038 50B58004
w 103C 3845800A
w 1040 50B58004
w 1044 3855800A
w 1048 50B58004
w 104C 3865800A
w 1050 50B58004
w 1054 3875800A
w 1058 50B58004
w 105C 3885800A
w 1060 50B58004
w 1064 3895800A
w 1068 50B58004
w 106C 38A5800A
w 1070 00000000
run 0 0
r 0000 00000002
r 0004 0000001C
r 2080 FFFFFFF0
r 2084 00012335
r 2088 00012355
r 208C 00012340
r 2090 FFFFFFF5
r 2094 FFFEDCB5
r 2098 00012344
r 209C 00017345
r 20A0 FFFFBCD1
# data preloads for program B
w 2100 CAFEF00D
w 2104 13579BDF
w 2108 2468ACE0
w 2180 FFFFFFFF
w 2200 00C0FFEE
# program B: shifts, srli nop on r3, indexed lw/sw, lw into r0
w 1000 44180001
w 1004 40209009
w 1008 4030A008
w 100C 4040900B
w 1010 4050FC0B
w 1014 4060FC08
w 1018 40308009
w 101C 44700100
w 1020 44800001
w 1024 3893A202
w 1028 38A3A302
w 102C 38038002
w 1030 44B00180
w 1034 3895A20A
w 1038 38A5A30A
w 103C 3805800A
w 1040 44D001C0
w 1044 3826800A
w 1048 50D68004
w 104C 3836800A
w 1050 50D68004
w 1054 3846800A
w 1058 50D68004
w 105C 3856800A
w 1060 50D68004
w 1064 3866800A
w 1068 00000000
# refused while idle: imem read, unmapped, count write
er 1000 0
er 3000 0
ew 0008 0
ew 0004 5
# refused while busy
go 0 0
r 0000 00000001
ew 2200 11111111
er 2184 0
ew 1100 FFFFFFFF
wait 0 0
r 0000 00000002
r 0004 0000001A
r 2200 00C0FFEE
r 2180 00000000
r 2184 13579BDF
r 2188 2468ACE0
r 21C0 0FFF8000
r 21C4 F8000100
r 21C8 1FFF8000
r 21CC FFF00003
r 21D0 80000000
